// File: include/systolic_params.svh
`ifndef SYSTOLIC_PARAMS_SVH
`define SYSTOLIC_PARAMS_SVH

// sample and coefficient width
`define SYS_DATA_WIDTH 8

// accumulator, product and result width
`define SYS_ACC_WIDTH 20

// elements in the row
`define SYS_NUM_PE 4

`endif

// File: hw/systolicPkg.sv
`default_nettype none

`include "systolic_params.svh"

package systolicPkg;

  // ========================================
  // word types
  // ========================================
  typedef logic [`SYS_DATA_WIDTH-1:0] sampleT;
  typedef logic [`SYS_DATA_WIDTH-1:0] coefT;
  typedef logic [`SYS_ACC_WIDTH-1:0] accT;            // also the product width
  typedef logic [$clog2(`SYS_NUM_PE)-1:0] coefAddrT;

  // ========================================
  // operand mode
  // ========================================
  typedef enum logic {
    opDiff = 1'b0,                                      // current minus previous
    opSum  = 1'b1                                       // current plus previous
  } opModeE;

endpackage

`default_nettype wire

// File: hw/coefficientBank.sv
`timescale 1ns/100ps
`default_nettype none

`include "systolic_params.svh"

module coefficientBank #(
  parameter int NUM_PE = `SYS_NUM_PE
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 coefWrite,
  input  wire systolicPkg::coefAddrT coefAddr,
  input  wire systolicPkg::coefT    coefData,
  output systolicPkg::coefT         coefficients [NUM_PE]
);

  // one register per element, written by address
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_PE; i++) begin
        coefficients[i] <= '0;
      end
    end else if (coefWrite) begin
      for (int i = 0; i < NUM_PE; i++) begin
        if (int'(coefAddr) == i) begin                  // addresses past NUM_PE are dropped
          coefficients[i] <= coefData;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/processingElement.sv
`timescale 1ns/100ps
`default_nettype none

module processingElement (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire systolicPkg::sampleT xIn,
  input  wire systolicPkg::opModeE modeIn,
  input  wire logic              startIn,
  input  wire systolicPkg::coefT coefficient,
  input  wire systolicPkg::accT  zIn,
  input  wire logic              zValidIn,
  output systolicPkg::sampleT    xOut,
  output systolicPkg::opModeE    modeOut,
  output logic                   startOut,
  output systolicPkg::accT       zOut,
  output logic                   zValidOut
);

  import systolicPkg::*;

  sampleT xStage1;
  sampleT xStage2;
  opModeE modeStage1;
  opModeE modeStage2;
  logic   startStage1;
  logic   startStage2;

  coefT   coefLatched;
  coefT   coefActive;
  accT    operand;
  accT    product;
  accT    accumulator;
  logic   windowOpen;

  // ========================================
  // row pipeline
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      xStage1     <= '0;
      xStage2     <= '0;
      modeStage1  <= opDiff;
      modeStage2  <= opDiff;
      startStage1 <= 1'b0;
      startStage2 <= 1'b0;
    end else begin
      xStage1     <= xIn;
      xStage2     <= xStage1;                           // previous sample in the stream
      modeStage1  <= modeIn;
      modeStage2  <= modeStage1;
      startStage1 <= startIn;
      startStage2 <= startStage1;
    end
  end

  assign xOut     = xStage2;
  assign modeOut  = modeStage2;
  assign startOut = startStage2;

  // ========================================
  // operand and multiply-accumulate
  // ========================================
  assign coefActive = startStage1 ? coefficient : coefLatched;  // first product of a window

  always_comb begin
    if (modeStage1 == opSum) begin
      operand = accT'(xStage1) + accT'(xStage2);
    end else begin
      operand = accT'(xStage1) - accT'(xStage2);        // wraps modulo 2^ACC_WIDTH
    end
  end

  assign product = accT'(coefActive) * operand;

  always_ff @(posedge clk) begin
    if (reset) begin
      accumulator <= '0;
      coefLatched <= '0;
      windowOpen  <= 1'b0;
    end else if (startStage1) begin
      accumulator <= product;                           // restart window
      coefLatched <= coefficient;
      windowOpen  <= 1'b1;
    end else begin
      accumulator <= accumulator + product;
    end
  end

  // ========================================
  // result chain
  // ========================================
  // the chain never carries a valid word into the start cycle,
  // so taking the local total here loses nothing
  always_ff @(posedge clk) begin
    if (reset) begin
      zOut      <= '0;
      zValidOut <= 1'b0;
    end else if (startStage1 && windowOpen) begin
      zOut      <= accumulator;                         // finished total of the old window
      zValidOut <= 1'b1;
    end else begin
      zOut      <= zIn;
      zValidOut <= zValidIn;
    end
  end

endmodule

`default_nettype wire

// File: hw/systolicRow.sv
`timescale 1ns/100ps
`default_nettype none

`include "systolic_params.svh"

module systolicRow #(
  parameter int NUM_PE = `SYS_NUM_PE
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire systolicPkg::sampleT sample,
  input  wire systolicPkg::opModeE opMode,
  input  wire logic                frameStart,
  input  wire systolicPkg::coefT   coefficients [NUM_PE],
  output systolicPkg::accT         result,
  output logic                     resultValid
);

  import systolicPkg::*;

  // index k is the input of element k
  sampleT xChain      [NUM_PE+1];
  opModeE modeChain   [NUM_PE+1];
  logic   startChain  [NUM_PE+1];
  accT    zChain      [NUM_PE+1];
  logic   zValidChain [NUM_PE+1];

  // ========================================
  // row ends
  // ========================================
  assign xChain[0]      = sample;
  assign modeChain[0]   = opMode;
  assign startChain[0]  = frameStart;
  assign zChain[0]      = '0;                           // nothing ahead of element 0
  assign zValidChain[0] = 1'b0;

  // ========================================
  // element chain
  // ========================================
  for (genvar k = 0; k < NUM_PE; k++) begin : genPe
    processingElement pe (
      .clk         (clk),
      .reset       (reset),
      .xIn         (xChain[k]),
      .modeIn      (modeChain[k]),
      .startIn     (startChain[k]),
      .coefficient (coefficients[k]),
      .zIn         (zChain[k]),
      .zValidIn    (zValidChain[k]),
      .xOut        (xChain[k+1]),
      .modeOut     (modeChain[k+1]),
      .startOut    (startChain[k+1]),
      .zOut        (zChain[k+1]),
      .zValidOut   (zValidChain[k+1])
    );
  end

  assign result      = zChain[NUM_PE];                  // last element feeds the output
  assign resultValid = zValidChain[NUM_PE];

endmodule

`default_nettype wire

// File: hw/filterTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "systolic_params.svh"

module filterTop (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire systolicPkg::sampleT   sample,
  input  wire systolicPkg::opModeE   opMode,
  input  wire logic                  frameStart,
  input  wire logic                  coefWrite,
  input  wire systolicPkg::coefAddrT coefAddr,
  input  wire systolicPkg::coefT     coefData,
  output systolicPkg::accT           result,
  output logic                       resultValid
);

  import systolicPkg::*;

  coefT coefficients [`SYS_NUM_PE];                     // one per element

  // ========================================
  // coefficient store
  // ========================================
  coefficientBank #(
    .NUM_PE (`SYS_NUM_PE)
  ) bank (
    .clk          (clk),
    .reset        (reset),
    .coefWrite    (coefWrite),
    .coefAddr     (coefAddr),
    .coefData     (coefData),
    .coefficients (coefficients)
  );

  // ========================================
  // systolic row
  // ========================================
  systolicRow #(
    .NUM_PE (`SYS_NUM_PE)
  ) row (
    .clk          (clk),
    .reset        (reset),
    .sample       (sample),
    .opMode       (opMode),
    .frameStart   (frameStart),
    .coefficients (coefficients),
    .result       (result),
    .resultValid  (resultValid)
  );

endmodule

`default_nettype wire

// File: dv/filterTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "systolic_params.svh"

module filterTb;

  import systolicPkg::*;

  localparam int NUM_PE      = `SYS_NUM_PE;
  localparam int DRAIN_LIMIT = 8 * NUM_PE + 8;          // cycles allowed for totals to leave

  logic     clk;
  logic     reset;
  sampleT   sample;
  opModeE   opMode;
  logic     frameStart;
  logic     coefWrite;
  coefAddrT coefAddr;
  coefT     coefData;
  accT      result;
  logic     resultValid;

  accT         expQ [$];                                 // expected totals in output order
  string       nameQ [$];                                // test that closed each window
  string       testName;
  int          checkCount;
  int          errorCount;
  int          validCount;
  int          checkStart;
  int          errorStart;
  accT         expVal;
  string       expName;

  // stream model
  coefT   coefModel [NUM_PE];                            // bank contents as written
  coefT   winCoefs [NUM_PE];                             // coefficients of the open window
  sampleT winSamples [$];
  opModeE winModes [$];
  sampleT winPrev;
  sampleT lastSample;
  logic   winOpen;

  filterTop uut (
    .clk         (clk),
    .reset       (reset),
    .sample      (sample),
    .opMode      (opMode),
    .frameStart  (frameStart),
    .coefWrite   (coefWrite),
    .coefAddr    (coefAddr),
    .coefData    (coefData),
    .result      (result),
    .resultValid (resultValid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ========================================
  // reference model
  // ========================================
  function automatic accT expectedTotal(input coefT coef, input sampleT samples [$],
                                        input opModeE modes [$], input sampleT prevSample);
    longint total;
    longint prev;
    longint cur;
    longint op;
    total = 0;
    prev  = prevSample;
    foreach (samples[i]) begin
      cur = samples[i];
      if (modes[i] == opSum) begin
        op = cur + prev;
      end else begin
        op = cur - prev;
      end
      total += longint'(coef) * op;
      prev = cur;
    end
    return accT'(total);                                 // keep the low ACC_WIDTH bits
  endfunction

  function automatic opModeE randomMode();
    if ($urandom % 2 == 1) begin
      return opSum;
    end
    return opDiff;
  endfunction

  task automatic closeWindow();
    for (int k = 0; k < NUM_PE; k++) begin
      expQ.push_back(expectedTotal(winCoefs[k], winSamples, winModes, winPrev));
      nameQ.push_back(testName);
    end
  endtask

  // ========================================
  // stimulus helpers
  // ========================================
  task automatic driveCycle(input sampleT s, input opModeE m, input logic fs,
                            input logic we, input coefAddrT a, input coefT d);
    @(posedge clk);
    #2;
    sample     = s;
    opMode     = m;
    frameStart = fs;
    coefWrite  = we;
    coefAddr   = a;
    coefData   = d;
    if (fs) begin
      if (winOpen) begin
        closeWindow();
      end
      winOpen = 1'b1;
      winPrev = lastSample;                              // previous sample crosses the boundary
      winSamples.delete();
      winModes.delete();
      for (int k = 0; k < NUM_PE; k++) begin
        winCoefs[k] = coefModel[k];
      end
    end
    if (winOpen) begin
      winSamples.push_back(s);
      winModes.push_back(m);
    end
    lastSample = s;
    if (we) begin
      coefModel[int'(a)] = d;
    end
  endtask

  task automatic sendSample(input sampleT s, input opModeE m, input logic fs);
    driveCycle(s, m, fs, 1'b0, '0, '0);
  endtask

  task automatic idleCycle();
    sendSample(sampleT'($urandom), randomMode(), 1'b0);
  endtask

  task automatic writeCoef(input int addr, input int data);
    driveCycle(sampleT'($urandom), randomMode(), 1'b0, 1'b1, coefAddrT'(addr), coefT'(data));
  endtask

  task automatic drainResults();
    int waited;
    waited = 0;
    while (expQ.size() > 0 && waited < DRAIN_LIMIT) begin
      idleCycle();
      waited++;
    end
    assert (expQ.size() == 0) else begin
      $display("Timed out after %0d cycles with %0d totals still missing in test %s",
               waited, expQ.size(), testName);
      errorCount++;
      expQ.delete();
      nameQ.delete();
    end
    idleCycle();
    idleCycle();
  endtask

  task automatic closeAndDrain();
    sendSample(sampleT'($urandom), randomMode(), 1'b1);
    drainResults();
  endtask

  task automatic startTest(input string name);
    testName   = name;
    checkStart = checkCount;
    errorStart = errorCount;
  endtask

  task automatic finishTest();
    $display("Test %-14s %0d checks, %0d errors", testName,
             checkCount - checkStart, errorCount - errorStart);
  endtask

  // ========================================
  // comparing process
  // ========================================
  always @(negedge clk) begin
    if (!reset && resultValid) begin
      validCount++;
      assert (expQ.size() > 0) else begin
        $display("Result 0x%05h arrived with no total pending in test %s", result, testName);
        errorCount++;
      end
      if (expQ.size() > 0) begin
        expVal  = expQ.pop_front();
        expName = nameQ.pop_front();
        checkCount++;
        assert (result === expVal) else begin
          $display("Fail %s: expected 0x%05h, actual 0x%05h", expName, expVal, result);
          errorCount++;
        end
      end
    end
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin
    int len;
    reset      = 1'b1;
    sample     = '0;
    opMode     = opDiff;
    frameStart = 1'b0;
    coefWrite  = 1'b0;
    coefAddr   = '0;
    coefData   = '0;
    checkCount = 0;
    errorCount = 0;
    validCount = 0;
    winOpen    = 1'b0;
    winPrev    = '0;
    lastSample = '0;                                     // pipeline is zero after reset
    testName   = "reset";
    for (int k = 0; k < NUM_PE; k++) begin
      coefModel[k] = '0;
      winCoefs[k]  = '0;
    end
    void'($urandom(32'h684a));
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    startTest("noFirstOutput");
    for (int k = 0; k < NUM_PE; k++) begin
      writeCoef(k, k + 1);
    end
    for (int i = 0; i < 3; i++) begin
      idleCycle();
    end
    sendSample(sampleT'($urandom), randomMode(), 1'b1);  // opens the first window only
    for (int i = 0; i < 3 * NUM_PE; i++) begin
      idleCycle();
    end
    assert (validCount == 0) else begin
      $display("Result valid was seen before the second frame start");
      errorCount++;
    end
    closeAndDrain();
    finishTest();

    startTest("sumMode");
    writeCoef(0, 3);
    writeCoef(1, 5);
    writeCoef(2, 7);
    writeCoef(3, 11);
    sendSample(sampleT'($urandom), opSum, 1'b1);
    for (int i = 0; i < 11; i++) begin
      sendSample(sampleT'($urandom), opSum, 1'b0);
    end
    closeAndDrain();
    finishTest();

    startTest("diffWrap");
    writeCoef(0, 255);
    writeCoef(1, 254);
    writeCoef(2, 128);
    writeCoef(3, 1);
    sendSample(sampleT'(255), opDiff, 1'b0);             // high sample ahead of the window
    sendSample(sampleT'(250), opDiff, 1'b1);
    for (int i = 1; i < 20; i++) begin
      sendSample(sampleT'(250 - 12 * i), opDiff, 1'b0);  // falling, so every operand is negative
    end
    closeAndDrain();
    finishTest();

    startTest("mixedModes");
    for (int k = 0; k < NUM_PE; k++) begin
      writeCoef(k, int'($urandom % 256));
    end
    for (int w = 0; w < 3; w++) begin
      len = NUM_PE + 1 + int'($urandom % 16);
      sendSample(sampleT'($urandom), randomMode(), 1'b1);
      for (int i = 1; i < len; i++) begin
        idleCycle();
      end
    end
    closeAndDrain();
    finishTest();

    startTest("coefRewrite");
    writeCoef(0, 9);
    writeCoef(1, 19);
    writeCoef(2, 29);
    writeCoef(3, 39);
    sendSample(sampleT'($urandom), randomMode(), 1'b1);
    for (int i = 0; i < 2 * NUM_PE; i++) begin
      idleCycle();
    end
    writeCoef(0, 200);                                   // late in the window, used by the next one
    writeCoef(1, 100);
    writeCoef(2, 50);
    writeCoef(3, 25);
    idleCycle();
    idleCycle();
    sendSample(sampleT'($urandom), randomMode(), 1'b1);
    for (int i = 0; i < 2 * NUM_PE + 2; i++) begin
      idleCycle();
    end
    closeAndDrain();
    finishTest();

    startTest("backToBack");
    for (int w = 0; w < 12; w++) begin
      sendSample(sampleT'($urandom), randomMode(), 1'b1);
      for (int i = 1; i < NUM_PE; i++) begin
        idleCycle();
      end
    end
    closeAndDrain();
    finishTest();

    $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hw/systolicPkg.sv
hw/coefficientBank.sv
hw/processingElement.sv
hw/systolicRow.sv
hw/filterTop.sv
dv/filterTb.sv

// File: Bender.yml
package:
  name: systolic_filter

export_include_dirs:
  - include

sources:
  # design sources in compile order
  - files:
      - hw/systolicPkg.sv
      - hw/coefficientBank.sv
      - hw/processingElement.sv
      - hw/systolicRow.sv
      - hw/filterTop.sv

  # testbench, top module filterTb
  - target: test
    files:
      - dv/filterTb.sv
